/* cache_macros.svh */
// cache geometry macros, address field widths for the two-way data cache
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ----------------------------------------
// address and word
`define CACHE_ADDR_W     32
`define CACHE_WORD_W     32

// ----------------------------------------
// line layout
`define CACHE_LINE_WORDS 4
`define CACHE_OFFSET_W   4  // byte offset within a line
`define CACHE_WORDSEL_W  2

// sets and tag
`define CACHE_SETS       16
`define CACHE_INDEX_W    4
`define CACHE_TAG_W      (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`endif

/* cache_pkg.sv */
// cache package, opcode, controller state and status enums plus tag and line types
`include "cache_macros.svh"

package cache_pkg;

	typedef enum logic [1:0] {
		opRead,
		opWrite,
		opInvalidate
	} cacheOp;

	typedef enum logic [2:0] {
		stIdle,
		stLookup,
		stFlush,     // victim write-back request
		stFlushWait,
		stFill,      // line read request
		stFillWait,
		stFinish
	} ctrlState;

	typedef enum logic [2:0] {
		statHit,
		statMiss,
		statInvalClean,
		statInvalFlushed,
		statAbsent
	} respStatus;

	typedef logic [`CACHE_TAG_W-1:0] cacheTag;
	typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_W-1:0] cacheLine;  // word 0 low

endpackage

/* cacheIf.sv */
// cache internal ports, tag lookup/update and data word/line access interfaces
`timescale 1ns/1ps
`include "cache_macros.svh"

interface tagPortIf;
	logic [`CACHE_INDEX_W-1:0] index;
	cache_pkg::cacheTag lookupTag;
	// update side
	logic update;
	logic updWay;
	cache_pkg::cacheTag updTag;
	logic setValid;
	logic clearValid;
	logic setDirty;
	logic clearDirty;
	logic touch;
	logic touchWay;
	// lookup results
	logic hit;
	logic hitWay;
	logic victimWay;
	logic victimValid;
	logic victimDirty;
	cache_pkg::cacheTag victimTag;

	modport controller (
		output index, lookupTag, update, updWay, updTag, setValid, clearValid,
		output setDirty, clearDirty, touch, touchWay,
		input hit, hitWay, victimWay, victimValid, victimDirty, victimTag
	);
	modport store (
		input index, lookupTag, update, updWay, updTag, setValid, clearValid,
		input setDirty, clearDirty, touch, touchWay,
		output hit, hitWay, victimWay, victimValid, victimDirty, victimTag
	);
endinterface

interface dataPortIf;
	logic [`CACHE_INDEX_W-1:0] index;
	logic way;
	logic [`CACHE_WORDSEL_W-1:0] wordSel;
	logic wordWe;
	logic [`CACHE_WORD_W-1:0] wordIn;
	logic lineWe;
	cache_pkg::cacheLine lineIn;
	logic [`CACHE_WORD_W-1:0] wordOut;
	cache_pkg::cacheLine lineOut;

	modport controller (output index, way, wordSel, wordWe, wordIn, lineWe, lineIn,
		input wordOut, lineOut);
	modport store (input index, way, wordSel, wordWe, wordIn, lineWe, lineIn,
		output wordOut, lineOut);
endinterface

/* cacheTagStore.sv */
// tag store, per-way tags with valid/dirty bits and per-set LRU, hit and victim lookup
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheTagStore (
	input logic clk,
	input logic reset,
	tagPortIf.store tagPort
);

	cache_pkg::cacheTag tags [2][`CACHE_SETS];
	logic [1:0] validBits [`CACHE_SETS];  // one bit per way
	logic [1:0] dirtyBits [`CACHE_SETS];
	logic lruWay [`CACHE_SETS];           // least recently used way of the set
	logic hit0;
	logic hit1;

	// ----------------------------------------
	// lookup
	always_comb begin
		hit0 = validBits[tagPort.index][0] && (tags[0][tagPort.index] == tagPort.lookupTag);
		hit1 = validBits[tagPort.index][1] && (tags[1][tagPort.index] == tagPort.lookupTag);
		tagPort.hit = hit0 | hit1;
		tagPort.hitWay = ~hit0;

		// on a hit the reported line is the hit line itself, which invalidate drops
		if (tagPort.hit)
			tagPort.victimWay = tagPort.hitWay;
		else if (!validBits[tagPort.index][0])
			tagPort.victimWay = 1'b0;
		else if (!validBits[tagPort.index][1])
			tagPort.victimWay = 1'b1;
		else
			tagPort.victimWay = lruWay[tagPort.index];

		tagPort.victimValid = validBits[tagPort.index][tagPort.victimWay];
		tagPort.victimDirty = dirtyBits[tagPort.index][tagPort.victimWay];
		tagPort.victimTag = tags[tagPort.victimWay][tagPort.index];
	end

	// ----------------------------------------
	// state bits
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				validBits[s] <= 2'b00;
				dirtyBits[s] <= 2'b00;
				lruWay[s] <= 1'b0;
			end
		end else begin
			if (tagPort.update) begin
				if (tagPort.setValid)
					validBits[tagPort.index][tagPort.updWay] <= 1'b1;
				else if (tagPort.clearValid)
					validBits[tagPort.index][tagPort.updWay] <= 1'b0;
				if (tagPort.setDirty)  // a write miss sets dirty while filling
					dirtyBits[tagPort.index][tagPort.updWay] <= 1'b1;
				else if (tagPort.clearDirty)
					dirtyBits[tagPort.index][tagPort.updWay] <= 1'b0;
			end
			if (tagPort.touch)
				lruWay[tagPort.index] <= ~tagPort.touchWay;
		end
	end

	always_ff @(posedge clk) begin
		if (tagPort.update)
			tags[tagPort.updWay][tagPort.index] <= tagPort.updTag;
	end

endmodule

/* cacheDataStore.sv */
// data store, two ways of lines with a word port and a whole-line port
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheDataStore (
	input logic clk,
	dataPortIf.store dataPort
);

	cache_pkg::cacheLine lines [2][`CACHE_SETS];
	cache_pkg::cacheLine lineNext;

	// reads
	always_comb begin
		dataPort.lineOut = lines[dataPort.way][dataPort.index];
		dataPort.wordOut = dataPort.lineOut[dataPort.wordSel];
	end

	// ----------------------------------------
	// word write lands on top of a line fill
	always_comb begin
		lineNext = dataPort.lineWe ? dataPort.lineIn : lines[dataPort.way][dataPort.index];
		if (dataPort.wordWe)
			lineNext[dataPort.wordSel] = dataPort.wordIn;
	end

	always_ff @(posedge clk) begin
		if (dataPort.lineWe || dataPort.wordWe)
			lines[dataPort.way][dataPort.index] <= lineNext;
	end

endmodule

/* cacheController.sv */
// cache controller, request capture and lookup/flush/fill sequencing
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheController (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input cache_pkg::cacheOp reqOp,
	input logic [`CACHE_ADDR_W-1:0] reqAddr,
	input logic [`CACHE_WORD_W-1:0] reqWdata,
	output logic busy,
	tagPortIf.controller tagPort,
	dataPortIf.controller dataPort,
	output logic memReqValid,
	output logic memWrite,
	output logic [`CACHE_ADDR_W-1:0] memAddr,
	output cache_pkg::cacheLine memWline,
	input logic memRespValid,
	input cache_pkg::cacheLine memRline,
	output logic finish,
	output cache_pkg::respStatus finStatus,
	output logic [`CACHE_WORD_W-1:0] finWord
);

	cache_pkg::ctrlState state;
	cache_pkg::ctrlState nextState;
	logic finishQ;  // done cycle of the response stage
	// captured request
	cache_pkg::cacheOp opQ;
	cache_pkg::cacheTag tagQ;
	logic [`CACHE_INDEX_W-1:0] indexQ;
	logic [`CACHE_WORDSEL_W-1:0] wordSelQ;
	logic [`CACHE_WORD_W-1:0] wdataQ;
	// line picked at lookup
	logic wayQ;
	cache_pkg::cacheTag victimTagQ;
	logic selWay;
	logic curWay;
	logic [`CACHE_WORD_W-1:0] readHold;
	logic isWrite;
	logic isInval;

	assign busy = (state != cache_pkg::stIdle) || finishQ;
	assign isWrite = (opQ == cache_pkg::opWrite);
	assign isInval = (opQ == cache_pkg::opInvalidate);
	assign selWay = tagPort.hit ? tagPort.hitWay : tagPort.victimWay;
	assign curWay = (state == cache_pkg::stLookup) ? selWay : wayQ;

	// ----------------------------------------
	// store addressing
	assign tagPort.index = indexQ;
	assign tagPort.lookupTag = tagQ;
	assign tagPort.updWay = curWay;
	assign tagPort.updTag = tagQ;
	assign tagPort.touchWay = curWay;
	assign dataPort.index = indexQ;
	assign dataPort.way = curWay;
	assign dataPort.wordSel = wordSelQ;
	assign dataPort.wordIn = wdataQ;
	assign dataPort.lineIn = memRline;

	// memory port
	assign memReqValid = (state == cache_pkg::stFlush) || (state == cache_pkg::stFill);
	assign memWrite = (state == cache_pkg::stFlush);
	assign memAddr = (state == cache_pkg::stFlush) ?
		{victimTagQ, indexQ, {`CACHE_OFFSET_W{1'b0}}} :
		{tagQ, indexQ, {`CACHE_OFFSET_W{1'b0}}};
	assign memWline = dataPort.lineOut;

	assign finWord = (opQ == cache_pkg::opRead) ? dataPort.wordOut : readHold;

	// ----------------------------------------
	// next state and strobes
	always_comb begin
		nextState = state;
		finish = 1'b0;
		finStatus = cache_pkg::statHit;
		tagPort.update = 1'b0;
		tagPort.setValid = 1'b0;
		tagPort.clearValid = 1'b0;
		tagPort.setDirty = 1'b0;
		tagPort.clearDirty = 1'b0;
		tagPort.touch = 1'b0;
		dataPort.wordWe = 1'b0;
		dataPort.lineWe = 1'b0;
		case (state)
			cache_pkg::stIdle:
				if (reqValid && !busy)
					nextState = cache_pkg::stLookup;
			cache_pkg::stLookup: begin
				if (isInval) begin
					if (!tagPort.hit) begin
						finish = 1'b1;
						finStatus = cache_pkg::statAbsent;
						nextState = cache_pkg::stIdle;
					end else if (tagPort.victimDirty) begin
						nextState = cache_pkg::stFlush;  // write back before dropping
					end else begin
						tagPort.update = 1'b1;
						tagPort.clearValid = 1'b1;
						finish = 1'b1;
						finStatus = cache_pkg::statInvalClean;
						nextState = cache_pkg::stIdle;
					end
				end else if (tagPort.hit) begin
					finish = 1'b1;
					tagPort.touch = 1'b1;
					dataPort.wordWe = isWrite;
					tagPort.update = isWrite;
					tagPort.setDirty = isWrite;
					nextState = cache_pkg::stIdle;
				end else if (tagPort.victimValid && tagPort.victimDirty) begin
					nextState = cache_pkg::stFlush;
				end else begin
					nextState = cache_pkg::stFill;
				end
			end
			cache_pkg::stFlush:
				nextState = cache_pkg::stFlushWait;
			cache_pkg::stFlushWait:
				if (memRespValid) begin
					if (isInval) begin
						tagPort.update = 1'b1;
						tagPort.clearValid = 1'b1;
						tagPort.clearDirty = 1'b1;
						finish = 1'b1;
						finStatus = cache_pkg::statInvalFlushed;
						nextState = cache_pkg::stIdle;
					end else begin
						nextState = cache_pkg::stFill;
					end
				end
			cache_pkg::stFill:
				nextState = cache_pkg::stFillWait;
			cache_pkg::stFillWait:
				if (memRespValid) begin
					dataPort.lineWe = 1'b1;
					dataPort.wordWe = isWrite;  // merged over the fill
					tagPort.update = 1'b1;
					tagPort.setValid = 1'b1;
					tagPort.setDirty = isWrite;
					tagPort.clearDirty = !isWrite;
					tagPort.touch = 1'b1;
					nextState = cache_pkg::stFinish;
				end
			cache_pkg::stFinish: begin
				finish = 1'b1;
				finStatus = cache_pkg::statMiss;
				nextState = cache_pkg::stIdle;
			end
			default:
				nextState = cache_pkg::stIdle;
		endcase
	end

	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cache_pkg::stIdle;
			finishQ <= 1'b0;
		end else begin
			state <= nextState;
			finishQ <= finish;
		end
	end

	always_ff @(posedge clk) begin
		if (state == cache_pkg::stIdle && reqValid && !busy) begin
			opQ <= reqOp;
			tagQ <= reqAddr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
			indexQ <= reqAddr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
			wordSelQ <= reqAddr[`CACHE_OFFSET_W-1 -: `CACHE_WORDSEL_W];
			wdataQ <= reqWdata;
		end
		if (state == cache_pkg::stLookup) begin
			wayQ <= selWay;
			victimTagQ <= tagPort.victimTag;
		end
		if (finish && opQ == cache_pkg::opRead)
			readHold <= finWord;  // last read word, reported on other ops
	end

endmodule

/* cacheResponse.sv */
// cache response stage, registers completion outputs and counts hits and misses
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheResponse (
	input logic clk,
	input logic reset,
	input logic finish,
	input cache_pkg::respStatus finStatus,
	input logic [`CACHE_WORD_W-1:0] finWord,
	output logic done,
	output cache_pkg::respStatus status,
	output logic [`CACHE_WORD_W-1:0] rdata,
	output logic [15:0] hitCount,
	output logic [15:0] missCount
);

	// ----------------------------------------
	// done and counters
	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
			hitCount <= '0;
			missCount <= '0;
		end else begin
			done <= finish;
			if (finish && finStatus == cache_pkg::statHit)
				hitCount <= hitCount + 16'd1;
			if (finish && finStatus == cache_pkg::statMiss)
				missCount <= missCount + 16'd1;  // invalidates count in neither
		end
	end

	// held until the next completion
	always_ff @(posedge clk) begin
		if (finish) begin
			status <= finStatus;
			rdata <= finWord;
		end
	end

endmodule

/* twoWayCache.sv */
// two-way set-associative write-back cache, top level wiring
`timescale 1ns/1ps
`include "cache_macros.svh"

module twoWayCache (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input cache_pkg::cacheOp reqOp,
	input logic [`CACHE_ADDR_W-1:0] reqAddr,
	input logic [`CACHE_WORD_W-1:0] reqWdata,
	output logic busy,
	output logic done,
	output cache_pkg::respStatus status,
	output logic [`CACHE_WORD_W-1:0] rdata,
	output logic [15:0] hitCount,
	output logic [15:0] missCount,
	output logic memReqValid,
	output logic memWrite,
	output logic [`CACHE_ADDR_W-1:0] memAddr,
	output cache_pkg::cacheLine memWline,
	input logic memRespValid,
	input cache_pkg::cacheLine memRline
);

	logic finish;
	cache_pkg::respStatus finStatus;
	logic [`CACHE_WORD_W-1:0] finWord;

	tagPortIf tagPort ();
	dataPortIf dataPort ();

	// ----------------------------------------
	cacheTagStore tagStore (
		.clk(clk), .reset(reset), .tagPort(tagPort.store)
	);

	cacheDataStore dataStore (
		.clk(clk), .dataPort(dataPort.store)
	);

	cacheController controller (
		.clk(clk), .reset(reset),
		.reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr), .reqWdata(reqWdata),
		.busy(busy),
		.tagPort(tagPort.controller), .dataPort(dataPort.controller),
		.memReqValid(memReqValid), .memWrite(memWrite), .memAddr(memAddr),
		.memWline(memWline), .memRespValid(memRespValid), .memRline(memRline),
		.finish(finish), .finStatus(finStatus), .finWord(finWord)
	);

	cacheResponse response (
		.clk(clk), .reset(reset),
		.finish(finish), .finStatus(finStatus), .finWord(finWord),
		.done(done), .status(status), .rdata(rdata),
		.hitCount(hitCount), .missCount(missCount)
	);

endmodule

/* twoWayCache_props.sv */
// cache top-level checks, strobe widths and busy/done relation
`timescale 1ns/1ps

module twoWayCache_props (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done,
	input logic memReqValid
);

	// ----------------------------------------
	// single-cycle strobes
	memReqPulse: assert property (@(posedge clk) disable iff (reset)
		memReqValid |=> !memReqValid)
		else $error("memReqValid held longer than one cycle");

	donePulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done held longer than one cycle");

	// busy covers the done cycle and drops right after it
	doneWhileBusy: assert property (@(posedge clk) disable iff (reset)
		done |-> busy ##1 !busy)
		else $error("busy window does not end with done");

	idleAfterReset: assert property (@(posedge clk)
		reset |=> (!busy && !done))
		else $error("busy or done high after reset");

endmodule

bind twoWayCache twoWayCache_props cacheProps (
	.clk(clk), .reset(reset), .busy(busy), .done(done), .memReqValid(memReqValid)
);

/* twoWayCache_tb.sv */
// testbench for the two-way cache, table-driven requests against a memory model with varying latency
`timescale 1ns/1ps

module twoWayCache_tb;

	localparam int RESET_CYCLES = 16;
	localparam int ROW_CYCLES = 40;

	typedef struct packed {
		cache_pkg::cacheOp op;
		logic [31:0] addr;
		logic [31:0] wdata;
		cache_pkg::respStatus status;
		logic [31:0] rdata;  // only used on reads
	} tableRow;

	logic clk;
	logic reset = 1'b1;
	logic reqValid = 1'b0;
	cache_pkg::cacheOp reqOp = cache_pkg::opRead;
	logic [31:0] reqAddr = 32'h0;
	logic [31:0] reqWdata = 32'h0;
	logic memRespValid = 1'b0;
	cache_pkg::cacheLine memRline = '0;
	logic busy;
	logic done;
	cache_pkg::respStatus status;
	logic [31:0] rdata;
	logic [15:0] hitCount;
	logic [15:0] missCount;
	logic memReqValid;
	logic memWrite;
	logic [31:0] memAddr;
	cache_pkg::cacheLine memWline;

	tableRow stimTable [$];
	logic rowsLoaded = 1'b0;
	int errorCount = 0;
	// memory model state
	cache_pkg::cacheLine mem [256];
	logic pending = 1'b0;
	logic pendWrite;
	logic [7:0] pendLine;
	logic [1:0] waitLeft;
	logic [31:0] rng = 32'h7300;

	twoWayCache twoWayCache_inst (
		.clk(clk), .reset(reset),
		.reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr), .reqWdata(reqWdata),
		.busy(busy), .done(done), .status(status), .rdata(rdata),
		.hitCount(hitCount), .missCount(missCount),
		.memReqValid(memReqValid), .memWrite(memWrite), .memAddr(memAddr),
		.memWline(memWline), .memRespValid(memRespValid), .memRline(memRline)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// initial memory word, its byte address scrambled
	function automatic logic [31:0] memRule(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'hA5A50000;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic addRow(input cache_pkg::cacheOp op, input logic [31:0] addr,
		input logic [31:0] wdata, input cache_pkg::respStatus st, input logic [31:0] rd);
		stimTable.push_back(tableRow'{op, addr, wdata, st, rd});
	endtask

	// ----------------------------------------
	// stimulus table
	task automatic loadTable();
		addRow(cache_pkg::opRead, 32'h104, 32'h0, cache_pkg::statMiss, memRule(32'h104));
		addRow(cache_pkg::opRead, 32'h10C, 32'h0, cache_pkg::statHit, memRule(32'h10C));
		addRow(cache_pkg::opWrite, 32'h108, 32'hDEAD0001, cache_pkg::statHit, 32'h0);
		addRow(cache_pkg::opRead, 32'h108, 32'h0, cache_pkg::statHit, 32'hDEAD0001);
		addRow(cache_pkg::opRead, 32'h100, 32'h0, cache_pkg::statHit, memRule(32'h100));
		// set 2, LRU replacement
		addRow(cache_pkg::opRead, 32'h020, 32'h0, cache_pkg::statMiss, memRule(32'h020));
		addRow(cache_pkg::opRead, 32'h124, 32'h0, cache_pkg::statMiss, memRule(32'h124));
		addRow(cache_pkg::opRead, 32'h028, 32'h0, cache_pkg::statHit, memRule(32'h028));
		addRow(cache_pkg::opRead, 32'h22C, 32'h0, cache_pkg::statMiss, memRule(32'h22C));
		addRow(cache_pkg::opRead, 32'h020, 32'h0, cache_pkg::statHit, memRule(32'h020));
		addRow(cache_pkg::opRead, 32'h120, 32'h0, cache_pkg::statMiss, memRule(32'h120));
		// set 3, dirty victim written back
		addRow(cache_pkg::opWrite, 32'h034, 32'h11112222, cache_pkg::statMiss, 32'h0);
		addRow(cache_pkg::opRead, 32'h130, 32'h0, cache_pkg::statMiss, memRule(32'h130));
		addRow(cache_pkg::opRead, 32'h230, 32'h0, cache_pkg::statMiss, memRule(32'h230));
		addRow(cache_pkg::opRead, 32'h034, 32'h0, cache_pkg::statMiss, 32'h11112222);
		// set 5, invalidates
		addRow(cache_pkg::opRead, 32'h050, 32'h0, cache_pkg::statMiss, memRule(32'h050));
		addRow(cache_pkg::opInvalidate, 32'h054, 32'h0, cache_pkg::statInvalClean, 32'h0);
		addRow(cache_pkg::opRead, 32'h058, 32'h0, cache_pkg::statMiss, memRule(32'h058));
		addRow(cache_pkg::opWrite, 32'h15C, 32'hCAFEF00D, cache_pkg::statMiss, 32'h0);
		addRow(cache_pkg::opInvalidate, 32'h150, 32'h0, cache_pkg::statInvalFlushed, 32'h0);
		addRow(cache_pkg::opInvalidate, 32'h350, 32'h0, cache_pkg::statAbsent, 32'h0);
		addRow(cache_pkg::opRead, 32'h15C, 32'h0, cache_pkg::statMiss, 32'hCAFEF00D);
		addRow(cache_pkg::opRead, 32'h038, 32'h0, cache_pkg::statHit, memRule(32'h038));
	endtask

	// ----------------------------------------
	// memory model, one request at a time
	always @(posedge clk) begin
		memRespValid <= 1'b0;
		if (reset) begin
			pending <= 1'b0;
			for (int i = 0; i < 256; i++)
				for (int w = 0; w < 4; w++)
					mem[i][w] <= memRule(32'(i * 16 + w * 4));
		end else if (pending) begin
			if (waitLeft == 2'd0) begin
				memRespValid <= 1'b1;
				if (!pendWrite)
					memRline <= mem[pendLine];
				pending <= 1'b0;
			end else begin
				waitLeft <= waitLeft - 2'd1;
			end
		end else if (memReqValid) begin
			pending <= 1'b1;
			pendWrite <= memWrite;
			pendLine <= memAddr[11:4];
			waitLeft <= rng[1:0];  // 1 to 4 cycles
			rng <= xorshift(rng);
			if (memWrite)
				mem[memAddr[11:4]] <= memWline;
		end
	end

	// timeout
	initial begin
		int limit;
		int cycleCount;
		wait (rowsLoaded);
		limit = stimTable.size() * ROW_CYCLES + RESET_CYCLES;
		cycleCount = 0;
		while (cycleCount < limit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, the DUT stopped completing requests", cycleCount);
		$display("Test failed");
		$finish;
	end

	// ----------------------------------------
	// main sequence
	initial begin
		int errorsBefore;
		int lat;
		int expHits;
		int expMisses;
		logic [31:0] expRd;
		logic [31:0] lastRead;
		expHits = 0;
		expMisses = 0;
		lastRead = 32'h0;
		loadTable();
		rowsLoaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < stimTable.size(); i++) begin
			errorsBefore = errorCount;
			@(posedge clk);
			reqValid <= 1'b1;
			reqOp <= stimTable[i].op;
			reqAddr <= stimTable[i].addr;
			reqWdata <= stimTable[i].wdata;
			lat = 0;
			do begin
				@(posedge clk);
				reqValid <= 1'b0;
				lat++;
				@(negedge clk);
			end while (!done);

			checkValue("status", 32'(stimTable[i].status), 32'(status));
			// rdata only moves on reads
			expRd = (stimTable[i].op == cache_pkg::opRead) ? stimTable[i].rdata : lastRead;
			checkValue("rdata", expRd, rdata);
			lastRead = expRd;
			if (stimTable[i].status == cache_pkg::statHit ||
				stimTable[i].status == cache_pkg::statInvalClean ||
				stimTable[i].status == cache_pkg::statAbsent)
				checkValue("done latency", 32'd2, 32'(lat));
			if (stimTable[i].status == cache_pkg::statHit)
				expHits++;
			if (stimTable[i].status == cache_pkg::statMiss)
				expMisses++;
			$display("row %0d op %0d addr %h status %0d latency %0d: %s", i,
				stimTable[i].op, stimTable[i].addr, status, lat,
				(errorCount == errorsBefore) ? "ok" : "mismatch");
		end

		// written-back lines, and a dirty line still held in the cache
		checkValue("mem 0x034", 32'h11112222, mem[8'h03][1]);
		checkValue("mem 0x15C", 32'hCAFEF00D, mem[8'h15][3]);
		checkValue("mem 0x108", memRule(32'h108), mem[8'h10][2]);
		checkValue("hitCount", 32'(expHits), 32'(hitCount));
		checkValue("missCount", 32'(expMisses), 32'(missCount));

		$display("%0d rows, %0d hits, %0d misses, %0d errors", stimTable.size(),
			hitCount, missCount, errorCount);
		if (errorCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
cache_pkg.sv
cacheIf.sv
cacheTagStore.sv
cacheDataStore.sv
cacheController.sv
cacheResponse.sv
twoWayCache.sv
twoWayCache_props.sv
twoWayCache_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = twoWayCache_tb
FILELIST  = build.f
SOURCES   = $(wildcard *.sv *.svh)
BIN       = obj_dir/V$(TOP)
PASS_TEXT = Test completed successfully

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
